// ==== Bender.yml ====
package:
  name: fruit_report

sources:
  - common/report_pkg.sv
  - common/uart_pkg.sv
  - uart_tx/baud_tick_gen.sv
  - uart_tx/uart_serializer.sv
  - source/report_ctrl.sv
  - source/report_text.sv
  - source/fruit_report_top.sv
  - target: test
    files:
      - verif/uart_line_monitor.sv
      - verif/tb_fruit_report.sv

// ==== common/report_pkg.sv ====
`default_nettype none

package report_pkg;

    typedef enum logic [1:0] {
        MODE_NONE,
        MODE_COUNT,
        MODE_COLOR,
        MODE_DETECT
    } report_mode_t;

    typedef logic [7:0] report_value_t;  // count, or code zero-extended
    typedef logic [7:0] ascii_t;
    typedef logic [3:0] char_idx_t;

    localparam int FRAME_LEN = 9;        // chars per line, padding included
    localparam int MAX_COUNT = 10;

    // colour codes, 0/6/7 unused
    localparam logic [2:0] COLOR_RED    = 3'd1;
    localparam logic [2:0] COLOR_ORANGE = 3'd2;
    localparam logic [2:0] COLOR_YELLOW = 3'd3;
    localparam logic [2:0] COLOR_GREEN  = 3'd4;
    localparam logic [2:0] COLOR_PURPLE = 3'd5;

    localparam logic [2:0] FRUIT_APPLE  = 3'd0;
    localparam logic [2:0] FRUIT_BANANA = 3'd1;
    localparam logic [2:0] FRUIT_GRAPE  = 3'd2;
    localparam logic [2:0] FRUIT_PITAYA = 3'd3;
    localparam logic [2:0] FRUIT_PEAR   = 3'd4;
    localparam logic [2:0] FRUIT_MANGO  = 3'd5;
    localparam logic [2:0] FRUIT_KIWI   = 3'd6;
    localparam logic [2:0] FRUIT_ORANGE = 3'd7;

    localparam ascii_t CHAR_CR    = 8'h0d;
    localparam ascii_t CHAR_LF    = 8'h0a;
    localparam ascii_t CHAR_SPACE = 8'h20;

endpackage

`default_nettype wire

// ==== common/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    localparam int CLK_FREQ_HZ = 50_000_000;
    localparam int BAUD_RATE   = 115_200;

    // rounded, 434 at 50 MHz
    localparam int CLKS_PER_BIT = (CLK_FREQ_HZ + BAUD_RATE / 2) / BAUD_RATE;

    typedef logic [$clog2(CLKS_PER_BIT + 1)-1:0] baud_cnt_t;

    localparam int DATA_BITS  = 8;
    localparam int FRAME_BITS = DATA_BITS + 2;  // start + data + stop

    typedef logic [$clog2(FRAME_BITS)-1:0] bit_cnt_t;

endpackage

`default_nettype wire

// ==== source/fruit_report_top.sv ====
`default_nettype none

module fruit_report_top (
    input  wire                            sys_clk,
    input  wire                            rst_n,
    input  wire                            count_mode,
    input  wire                            color_mode,
    input  wire                            detect_mode,
    input  wire report_pkg::report_value_t fruit_count,
    input  wire [2:0]                      color_code,
    input  wire [2:0]                      subject_code,
    output logic                           uart_tx
);

    report_pkg::report_mode_t  report_mode;
    report_pkg::report_value_t report_value;
    report_pkg::char_idx_t     char_idx;
    report_pkg::ascii_t        tx_char;
    logic                      tx_start;
    logic                      tx_busy;

    report_ctrl u_report_ctrl (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .count_mode   (count_mode),
        .color_mode   (color_mode),
        .detect_mode  (detect_mode),
        .fruit_count  (fruit_count),
        .color_code   (color_code),
        .subject_code (subject_code),
        .tx_busy      (tx_busy),
        .report_mode  (report_mode),
        .report_value (report_value),
        .char_idx     (char_idx),
        .tx_start     (tx_start)
    );

    report_text u_report_text (
        .report_mode  (report_mode),
        .report_value (report_value),
        .char_idx     (char_idx),
        .tx_char      (tx_char)
    );

    // byte taken from the lookup in the start cycle
    uart_serializer u_uart_serializer (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_byte  (tx_char),
        .tx_busy  (tx_busy),
        .uart_tx  (uart_tx)
    );

endmodule

`default_nettype wire

// ==== source/report_ctrl.sv ====
`default_nettype none

module report_ctrl (
    input  wire                         sys_clk,
    input  wire                         rst_n,
    input  wire                         count_mode,
    input  wire                         color_mode,
    input  wire                         detect_mode,
    input  wire report_pkg::report_value_t fruit_count,
    input  wire [2:0]                   color_code,
    input  wire [2:0]                   subject_code,
    input  wire                         tx_busy,
    output report_pkg::report_mode_t    report_mode,
    output report_pkg::report_value_t   report_value,
    output report_pkg::char_idx_t       char_idx,
    output logic                        tx_start
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SEND,
        WAIT
    } state_t;

    state_t state;
    state_t state_nxt;

    report_pkg::report_mode_t  mode_sel;
    report_pkg::report_value_t value_sel;
    logic                      last_char;

    // count beats colour beats detect
    always_comb begin
        if (count_mode) begin
            mode_sel  = report_pkg::MODE_COUNT;
            value_sel = fruit_count;
        end else if (color_mode) begin
            mode_sel  = report_pkg::MODE_COLOR;
            value_sel = {5'd0, color_code};
        end else if (detect_mode) begin
            mode_sel  = report_pkg::MODE_DETECT;
            value_sel = {5'd0, subject_code};
        end else begin
            mode_sel  = report_pkg::MODE_NONE;
            value_sel = '0;
        end
    end

    assign last_char = (char_idx == report_pkg::char_idx_t'(report_pkg::FRAME_LEN - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: state_nxt = LOAD;
            LOAD: state_nxt = SEND;
            SEND: state_nxt = WAIT;
            WAIT: begin
                if (!tx_busy) begin
                    state_nxt = last_char ? LOAD : SEND;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            report_mode <= report_pkg::MODE_NONE;
            char_idx    <= '0;
        end else begin
            state <= state_nxt;
            if (state == LOAD) begin
                report_mode <= mode_sel;  // held for the whole frame
                char_idx    <= '0;
            end else if (state == WAIT && !tx_busy && !last_char) begin
                char_idx <= char_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == LOAD) begin
            report_value <= value_sel;
        end
    end

    assign tx_start = (state == SEND);  // busy is always low here

endmodule

`default_nettype wire

// ==== source/report_text.sv ====
`default_nettype none

module report_text (
    input  wire report_pkg::report_mode_t  report_mode,
    input  wire report_pkg::report_value_t report_value,
    input  wire report_pkg::char_idx_t     char_idx,
    output report_pkg::ascii_t             tx_char
);

    logic [47:0]           word_text;  // right-justified, up to 6 chars
    report_pkg::char_idx_t word_len;
    logic                  word_ok;

    always_comb begin
        word_text = '0;
        word_len  = '0;
        word_ok   = 1'b1;
        case (report_mode)
            report_pkg::MODE_COUNT: begin
                if (report_value < report_pkg::MAX_COUNT) begin
                    word_text = {40'd0, "0" + report_value};
                    word_len  = 4'd1;
                end else if (report_value == report_pkg::MAX_COUNT) begin
                    word_text = "10";
                    word_len  = 4'd2;
                end else begin
                    word_ok = 1'b0;
                end
            end
            report_pkg::MODE_COLOR: begin
                case (report_value)
                    report_pkg::COLOR_RED: begin
                        word_text = "RED";
                        word_len  = 4'd3;
                    end
                    report_pkg::COLOR_ORANGE: begin
                        word_text = "ORANGE";
                        word_len  = 4'd6;
                    end
                    report_pkg::COLOR_YELLOW: begin
                        word_text = "YELLOW";
                        word_len  = 4'd6;
                    end
                    report_pkg::COLOR_GREEN: begin
                        word_text = "GREEN";
                        word_len  = 4'd5;
                    end
                    report_pkg::COLOR_PURPLE: begin
                        word_text = "PURPLE";
                        word_len  = 4'd6;
                    end
                    default: word_ok = 1'b0;
                endcase
            end
            report_pkg::MODE_DETECT: begin
                case (report_value)
                    report_pkg::FRUIT_APPLE: begin
                        word_text = "APPLE";
                        word_len  = 4'd5;
                    end
                    report_pkg::FRUIT_BANANA: begin
                        word_text = "BANANA";
                        word_len  = 4'd6;
                    end
                    report_pkg::FRUIT_GRAPE: begin
                        word_text = "GRAPE";
                        word_len  = 4'd5;
                    end
                    report_pkg::FRUIT_PITAYA: begin
                        word_text = "PITAYA";
                        word_len  = 4'd6;
                    end
                    report_pkg::FRUIT_PEAR: begin
                        word_text = "PEAR";
                        word_len  = 4'd4;
                    end
                    report_pkg::FRUIT_MANGO: begin
                        word_text = "MANGO";
                        word_len  = 4'd5;
                    end
                    report_pkg::FRUIT_KIWI: begin
                        word_text = "KIWI";
                        word_len  = 4'd4;
                    end
                    report_pkg::FRUIT_ORANGE: begin
                        word_text = "ORANGE";
                        word_len  = 4'd6;
                    end
                    default: word_ok = 1'b0;  // upper value bits set
                endcase
            end
            default: word_ok = 1'b0;
        endcase
    end

    always_comb begin
        if (!word_ok) begin
            tx_char = report_pkg::CHAR_SPACE;
        end else if (char_idx < word_len) begin
            tx_char = word_text[8 * (word_len - char_idx - 1) +: 8];  // first char is msb
        end else if (char_idx == word_len) begin
            tx_char = report_pkg::CHAR_CR;
        end else if (char_idx == word_len + 4'd1) begin
            tx_char = report_pkg::CHAR_LF;
        end else begin
            tx_char = report_pkg::CHAR_SPACE;  // pad to frame length
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
common/report_pkg.sv
common/uart_pkg.sv
uart_tx/baud_tick_gen.sv
uart_tx/uart_serializer.sv
source/report_ctrl.sv
source/report_text.sv
source/fruit_report_top.sv
verif/uart_line_monitor.sv
verif/tb_fruit_report.sv

// ==== uart_tx/baud_tick_gen.sv ====
`default_nettype none

module baud_tick_gen (
    input  wire  sys_clk,
    input  wire  rst_n,
    input  wire  bit_restart,
    output logic bit_tick
);

    uart_pkg::baud_cnt_t cnt;

    // cnt reads k in the k-th cycle after restart
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (bit_restart || bit_tick) begin
            cnt <= uart_pkg::baud_cnt_t'(1);
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign bit_tick = (cnt == uart_pkg::baud_cnt_t'(uart_pkg::CLKS_PER_BIT));

endmodule

`default_nettype wire

// ==== uart_tx/uart_serializer.sv ====
`default_nettype none

module uart_serializer (
    input  wire                     sys_clk,
    input  wire                     rst_n,
    input  wire                     tx_start,
    input  wire report_pkg::ascii_t tx_byte,
    output logic                    tx_busy,
    output logic                    uart_tx
);

    logic                bit_restart;
    logic                bit_tick;
    uart_pkg::bit_cnt_t  bit_cnt;   // bit on the line, 0 is start
    report_pkg::ascii_t  shift_reg;

    assign bit_restart = tx_start && !tx_busy;

    baud_tick_gen u_baud_tick_gen (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .bit_restart (bit_restart),
        .bit_tick    (bit_tick)
    );

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            bit_cnt <= '0;
            uart_tx <= 1'b1;  // line idles high
        end else if (bit_restart) begin
            tx_busy <= 1'b1;
            bit_cnt <= '0;
            uart_tx <= 1'b0;  // start bit
        end else if (tx_busy && bit_tick) begin
            if (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::FRAME_BITS - 1)) begin
                tx_busy <= 1'b0;  // stop bit done
                uart_tx <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt < uart_pkg::bit_cnt_t'(uart_pkg::DATA_BITS)) begin
                    uart_tx <= shift_reg[0];  // lsb first
                end else begin
                    uart_tx <= 1'b1;  // stop bit
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (bit_restart) begin
            shift_reg <= tx_byte;
        end else if (tx_busy && bit_tick &&
                     bit_cnt < uart_pkg::bit_cnt_t'(uart_pkg::DATA_BITS)) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_fruit_report.sv ====
`default_nettype none

module tb_fruit_report;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PLANNED_FRAMES = 66;
    localparam int WATCHDOG_CYCLES =
        (PLANNED_FRAMES + 2) * report_pkg::FRAME_LEN * 12 * uart_pkg::CLKS_PER_BIT;

    logic        sys_clk = 1'b0;
    logic        rst_n;
    logic        count_mode;
    logic        color_mode;
    logic        detect_mode;
    logic [7:0]  fruit_count;
    logic [2:0]  color_code;
    logic [2:0]  subject_code;
    wire         uart_tx;
    wire         byte_valid;
    wire  [7:0]  byte_data;
    wire         frame_err;
    logic [71:0] frame_buf;  // first char in the top byte
    logic        frame_done;
    int          byte_cnt;
    int          errors = 0;
    int          checks = 0;
    integer      seed = 32'h9cd1;

    always #2 sys_clk = ~sys_clk;

    fruit_report_top u_fruit_report_top (.*);

    uart_line_monitor u_uart_line_monitor (.*);

    // line carries whole frames from the first start bit on
    always @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt   <= 0;
            frame_done <= 1'b0;
            frame_buf  <= '0;
        end else begin
            frame_done <= 1'b0;
            if (byte_valid) begin
                frame_buf  <= {frame_buf[63:0], byte_data};
                frame_done <= (byte_cnt == report_pkg::FRAME_LEN - 1);
                byte_cnt   <= (byte_cnt == report_pkg::FRAME_LEN - 1) ? 0 : byte_cnt + 1;
            end
        end
    end

    // every decoded byte ends on a high stop bit
    assert property (@(posedge sys_clk) disable iff (!rst_n) byte_valid |-> !frame_err)
        else begin
            errors = errors + 1;
            $display("ERR %0t frame_err exp=0 got=1 byte=%h", $time, byte_data);
        end

    function automatic logic [71:0] expected_frame(input logic cm, cl, dm,
                                                   input logic [7:0] cnt,
                                                   input logic [2:0] col, sub);
        string       w;
        logic [71:0] f;
        logic [7:0]  ch;
        int          i;
        w = "";
        if (cm) begin
            if (cnt <= 8'd10) begin
                w = $sformatf("%0d", cnt);
            end
        end else if (cl) begin
            case (col)
                3'd1: w = "RED";
                3'd2: w = "ORANGE";
                3'd3: w = "YELLOW";
                3'd4: w = "GREEN";
                3'd5: w = "PURPLE";
                default: w = "";
            endcase
        end else if (dm) begin
            case (sub)
                3'd0: w = "APPLE";
                3'd1: w = "BANANA";
                3'd2: w = "GRAPE";
                3'd3: w = "PITAYA";
                3'd4: w = "PEAR";
                3'd5: w = "MANGO";
                3'd6: w = "KIWI";
                default: w = "ORANGE";
            endcase
        end
        for (i = 0; i < report_pkg::FRAME_LEN; i++) begin
            if (w.len() == 0 || i > w.len() + 1) ch = report_pkg::CHAR_SPACE;
            else if (i < w.len()) ch = w[i];
            else if (i == w.len()) ch = report_pkg::CHAR_CR;
            else ch = report_pkg::CHAR_LF;
            f[8 * (report_pkg::FRAME_LEN - 1 - i) +: 8] = ch;
        end
        return f;
    endfunction

    task automatic apply_inputs(input logic cm, cl, dm, input logic [7:0] cnt,
                                input logic [2:0] col, sub);
        @(posedge sys_clk);
        count_mode   <= cm;
        color_mode   <= cl;
        detect_mode  <= dm;
        fruit_count  <= cnt;
        color_code   <= col;
        subject_code <= sub;
    endtask

    task automatic wait_frame();
        do @(posedge sys_clk); while (!frame_done);
    endtask

    task automatic check_frame(input logic [71:0] exp_a, exp_b);
        checks = checks + 1;
        assert (frame_buf == exp_a || frame_buf == exp_b) else begin
            errors = errors + 1;
            $display("ERR %0t frame_buf exp=%h alt=%h got=%h", $time, exp_a, exp_b, frame_buf);
        end
    endtask

    task automatic check_setting(input logic cm, cl, dm, input logic [7:0] cnt,
                                 input logic [2:0] col, sub);
        logic [71:0] exp;
        exp = expected_frame(cm, cl, dm, cnt, col, sub);
        apply_inputs(cm, cl, dm, cnt, col, sub);
        wait_frame();  // frame in flight may still hold the old result
        wait_frame();
        check_frame(exp, exp);
    endtask

    task automatic random_change();
        logic [31:0] r;
        logic [71:0] exp_old;
        logic [71:0] exp_new;
        exp_old = expected_frame(count_mode, color_mode, detect_mode, fruit_count,
                                 color_code, subject_code);
        r = $random(seed);
        exp_new = expected_frame(r[0], r[1], r[2], {4'd0, r[11:8]}, r[14:12], r[18:16]);
        repeat ({r[31:20], 3'd0}) @(posedge sys_clk);  // lands anywhere in a frame
        apply_inputs(r[0], r[1], r[2], {4'd0, r[11:8]}, r[14:12], r[18:16]);
        wait_frame();
        check_frame(exp_new, exp_old);
        wait_frame();
        check_frame(exp_new, exp_new);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        int          i;
        rst_n        = 1'b1;
        count_mode   = 1'b0;
        color_mode   = 1'b0;
        detect_mode  = 1'b0;
        fruit_count  = 8'd0;
        color_code   = 3'd0;
        subject_code = 3'd0;
        @(posedge sys_clk);
        rst_n <= 1'b0;
        for (i = 0; i < 5; i++) begin
            @(posedge sys_clk);
            checks = checks + 1;
            assert (uart_tx === 1'b1) else begin
                errors = errors + 1;
                $display("ERR %0t uart_tx exp=1 got=%b", $time, uart_tx);
            end
            if (i == 3) rst_n <= 1'b1;
        end
        check_setting(1'b1, 1'b0, 1'b0, 8'd0, 3'd0, 3'd0);
        check_setting(1'b1, 1'b0, 1'b0, 8'd7, 3'd0, 3'd0);
        check_setting(1'b1, 1'b0, 1'b0, 8'd10, 3'd0, 3'd0);
        repeat (3) begin
            r = $random(seed);
            check_setting(1'b1, 1'b0, 1'b0, 8'(r % 32'd11), 3'd0, 3'd0);
        end
        check_setting(1'b1, 1'b0, 1'b0, 8'd11, 3'd0, 3'd0);
        r = $random(seed);
        check_setting(1'b1, 1'b0, 1'b0, 8'(32'd11 + r % 32'd245), 3'd0, 3'd0);
        for (i = 0; i < 8; i++) begin
            check_setting(1'b0, 1'b1, 1'b0, 8'd0, 3'(i), 3'd0);
        end
        for (i = 0; i < 8; i++) begin
            check_setting(1'b0, 1'b0, 1'b1, 8'd0, 3'd0, 3'(i));
        end
        check_setting(1'b1, 1'b1, 1'b1, 8'd4, 3'd2, 3'd6);  // count wins
        check_setting(1'b0, 1'b1, 1'b1, 8'd4, 3'd2, 3'd6);
        check_setting(1'b0, 1'b0, 1'b0, 8'd4, 3'd2, 3'd6);
        repeat (4) random_change();
        $display("errors=%0d checks=%0d", errors, checks);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("run timed out before all frames were checked, errors=%0d checks=%0d",
                 errors, checks);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/uart_line_monitor.sv ====
`default_nettype none

module uart_line_monitor (
    input  wire        sys_clk,
    input  wire        rst_n,
    input  wire        uart_tx,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       frame_err
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_BIT = uart_pkg::CLKS_PER_BIT / 2;

    logic       in_byte;
    logic       line_q;
    int         cnt;
    int         bit_no;  // 0 start, 1..8 data, 9 stop
    logic [7:0] shreg;

    always @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_byte    <= 1'b0;
            line_q     <= 1'b1;
            cnt        <= 0;
            bit_no     <= 0;
            shreg      <= '0;
            byte_valid <= 1'b0;
            byte_data  <= '0;
            frame_err  <= 1'b0;
        end else begin
            line_q     <= uart_tx;
            byte_valid <= 1'b0;
            if (!in_byte) begin
                if (line_q && !uart_tx) begin  // falling edge of start bit
                    in_byte <= 1'b1;
                    cnt     <= 1;
                    bit_no  <= 0;
                end
            end else if (cnt < ((bit_no == 0) ? HALF_BIT : uart_pkg::CLKS_PER_BIT)) begin
                cnt <= cnt + 1;
            end else begin
                cnt    <= 1;
                bit_no <= bit_no + 1;
                if (bit_no == 0) begin
                    in_byte <= !uart_tx;  // glitch, not a real start bit
                end else if (bit_no <= uart_pkg::DATA_BITS) begin
                    shreg <= {uart_tx, shreg[7:1]};  // lsb first
                end else begin
                    in_byte    <= 1'b0;
                    byte_valid <= 1'b1;
                    byte_data  <= shreg;
                    frame_err  <= !uart_tx;
                end
            end
        end
    end

endmodule

`default_nettype wire
